//--- project.f
source/bus_pkg.sv
source/periph_pkg.sv
source/word_ram.sv
source/sd_sector_buffer.sv
source/key_irq_unit.sv
source/bus_fabric.sv
source/soc_bus_top.sv
verif/soc_bus_properties.sv
verif/tb_soc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the soc_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_soc_bus \
    -Mdir obj_dir \
    -o Vtb_soc_bus
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_soc_bus > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- source/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import bus_pkg::*, periph_pkg::*; (
    input  logic          CLOCK_50,
    input  logic          KEY0,
    input  bus_req_t      req,
    output bus_rsp_t      rsp,
    input  ram_word_t     ram_read_word,
    output logic          ram_read_strobe,
    output logic          ram_write_strobe,
    output logic [1:0]    ram_byte_offset,
    output ram_index_t    ram_word_index,
    output logic          ram_upper_half,
    input  logic [7:0]    sd_byte,
    output sector_index_t sd_index,
    input  logic          sd_cache_available,
    input  logic          sd_ready,
    input  key_code_t     key_code,
    output logic [31:0]   sd_sector_addr,
    output logic          sd_rd_start,
    output logic          uart_write,
    output logic [7:0]    uart_byte
);

    logic      ram_sel;
    logic      key_sel;
    logic      uart_sel;
    logic      sdc_addr_sel;
    logic      sdc_read_sel;
    logic      sdc_ready_sel;
    logic      sdc_avail_sel;
    logic      sdc_window_sel;
    logic      is_double;
    bus_addr_t ram_offset;
    bus_addr_t sd_offset;
    logic      read_done;
    logic      write_done;
    logic      second_phase;
    bus_data_t read_mux;
    bus_data_t read_data;

    // address decode, address held until done
    assign ram_sel        = (req.address >= RAM_BASE) && (req.address < RAM_LIMIT);
    assign key_sel        = (req.address == KEY_ADDR);
    assign uart_sel       = (req.address == UART_ADDR);
    assign sdc_addr_sel   = (req.address == SDC_ADDR_REG);
    assign sdc_read_sel   = (req.address == SDC_READ);
    assign sdc_ready_sel  = (req.address == SDC_READY);
    assign sdc_avail_sel  = (req.address == SDC_AVAIL);
    assign sdc_window_sel = (req.address >= SDC_BASE) && (req.address < SDC_BASE + SECTOR_BYTES);
    assign is_double      = (req.ls_type == LS_DOUBLE);

    // ram word index and byte lane
    assign ram_offset      = req.address - RAM_BASE;
    assign ram_word_index  = ram_offset[2 +: RAM_INDEX_W];
    assign ram_byte_offset = ram_offset[1:0];

    // byte within the sector window
    assign sd_offset = req.address - SDC_BASE;
    assign sd_index  = sd_offset[SECTOR_INDEX_W-1:0];

    // first pending cycle of a ram double issues the high word
    assign ram_upper_half   = ram_sel && is_double && !second_phase
                              && (!read_done || !write_done);
    assign ram_read_strobe  = ram_sel && (req.read_enable || (ram_upper_half && !read_done));
    assign ram_write_strobe = ram_sel && (req.write_enable || (ram_upper_half && !write_done));

    // read data by target, zero when nothing is mapped
    always_comb begin
        read_mux = '0;
        if (ram_sel) begin
            read_mux = bus_data_t'(ram_read_word);
        end else if (key_sel) begin
            read_mux = bus_data_t'(key_code);
        end else if (sdc_ready_sel) begin
            read_mux = bus_data_t'(sd_ready);
        end else if (sdc_avail_sel) begin
            read_mux = bus_data_t'(sd_cache_available);
        end else if (sdc_window_sel) begin
            // one byte for every load width
            read_mux = bus_data_t'(sd_byte);
        end
    end

    // done flags, double sequencing and the write-side registers
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done      <= 1'b1;
            write_done     <= 1'b1;
            second_phase   <= 1'b0;
            uart_write     <= 1'b0;
            sd_rd_start    <= 1'b0;
            sd_sector_addr <= '0;
        end else begin
            uart_write  <= 1'b0;
            sd_rd_start <= 1'b0;
            if (req.read_enable) begin
                read_done <= 1'b0;
            end
            if (req.write_enable) begin
                write_done <= 1'b0;
            end
            if (ram_upper_half) begin
                // low word done, one more cycle for the high word
                second_phase <= 1'b1;
            end else if (!read_done || !write_done) begin
                second_phase <= 1'b0;
                read_done    <= 1'b1;
                write_done   <= 1'b1;
                if (!write_done) begin
                    if (uart_sel) begin
                        uart_write <= 1'b1;
                    end
                    if (sdc_read_sel) begin
                        sd_rd_start <= 1'b1;
                    end
                    if (sdc_addr_sel) begin
                        sd_sector_addr <= req.write_data[31:0];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!read_done) begin
            if (ram_sel && is_double && second_phase) begin
                read_data[63:32] <= ram_read_word;
            end else begin
                read_data <= read_mux;
            end
        end
        // byte goes out with the uart strobe
        if (!write_done && uart_sel) begin
            uart_byte <= req.write_data[7:0];
        end
    end

    assign rsp.read_data  = read_data;
    assign rsp.read_done  = read_done;
    assign rsp.write_done = write_done;

endmodule

//--- source/bus_pkg.sv
package bus_pkg;

    // master side is 64 bits wide, address is a byte address
    typedef logic [63:0] bus_data_t;
    typedef logic [63:0] bus_addr_t;

    // on-chip ram is built from 32-bit words
    typedef logic [31:0] ram_word_t;
    localparam int RAM_WORDS   = 1024;
    localparam int RAM_INDEX_W = $clog2(RAM_WORDS);
    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

    // load/store kind, same encoding as the cpu uses
    // signed kinds 0..3, unsigned loads 4..6
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,
        LS_HALF   = 3'd1,
        LS_WORD   = 3'd2,
        LS_DOUBLE = 3'd3,
        LS_BYTE_U = 3'd4,
        LS_HALF_U = 3'd5,
        LS_WORD_U = 3'd6
    } ls_type_t;

    // master to fabric
    typedef struct packed {
        bus_addr_t address;
        bus_data_t write_data;
        ls_type_t  ls_type;
        logic      read_enable;
        logic      write_enable;
    } bus_req_t;

    // fabric to master
    typedef struct packed {
        bus_data_t read_data;
        logic      read_done;
        logic      write_done;
    } bus_rsp_t;

    // address map
    localparam bus_addr_t RAM_BASE     = 64'h0000_1000;
    localparam bus_addr_t RAM_LIMIT    = RAM_BASE + RAM_WORDS * 4;
    localparam bus_addr_t KEY_ADDR     = 64'h0000_8000;
    localparam bus_addr_t UART_ADDR    = 64'h0000_8008;
    localparam bus_addr_t SDC_ADDR_REG = 64'h0000_9000;
    localparam bus_addr_t SDC_READ     = 64'h0000_9008;
    localparam bus_addr_t SDC_READY    = 64'h0000_9010;
    localparam bus_addr_t SDC_AVAIL    = 64'h0000_9018;
    // sector window, one byte per address
    localparam bus_addr_t SDC_BASE     = 64'h0000_A000;

endpackage

//--- source/key_irq_unit.sv
`timescale 1ns/1ps

module key_irq_unit import periph_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        key_pressed,
    input  key_code_t   ascii,
    input  logic        irq_ack,
    output key_code_t   key_code,
    output irq_vector_t irq_vector
);

    logic pressed_d;
    logic press_valid;

    // new press with a printable code
    assign press_valid = key_pressed && !pressed_d && (ascii != KEY_NONE);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pressed_d  <= 1'b0;
            irq_vector <= IRQ_NONE;
        end else begin
            pressed_d <= key_pressed;
            if (press_valid) begin
                irq_vector <= IRQ_KEY;
            end
            // ack wins over a press in the same cycle
            if (irq_vector != IRQ_NONE && irq_ack) begin
                irq_vector <= IRQ_NONE;
            end
        end
    end

    // code kept until the next valid press
    always_ff @(posedge CLOCK_50) begin
        if (press_valid) begin
            key_code <= ascii;
        end
    end

endmodule

//--- source/periph_pkg.sv
package periph_pkg;

    // sd card sector buffer
    localparam int SECTOR_BYTES   = 512;
    localparam int SECTOR_INDEX_W = $clog2(SECTOR_BYTES);
    typedef logic [SECTOR_INDEX_W-1:0] sector_index_t;

    // index of the final byte in a sector
    localparam sector_index_t SECTOR_LAST = sector_index_t'(SECTOR_BYTES - 1);

    // keyboard side, ascii code from the ps/2 decoder
    typedef logic [7:0] key_code_t;

    // code zero means no printable key
    localparam key_code_t KEY_NONE = 8'h00;

    // interrupt vector seen by the cpu
    typedef logic [3:0] irq_vector_t;

    localparam irq_vector_t IRQ_NONE = 4'd0;
    // key press source
    localparam irq_vector_t IRQ_KEY  = 4'd1;

endpackage

//--- source/sd_sector_buffer.sv
`timescale 1ns/1ps

module sd_sector_buffer import periph_pkg::*; (
    input  logic          CLOCK_50,
    input  logic          KEY0,
    input  logic [7:0]    sd_dout,
    input  logic          sd_byte_available,
    input  logic          sd_rd_start,
    input  sector_index_t index,
    output logic [7:0]    byte_out,
    output logic          sd_cache_available
);

    logic [7:0]    sector_mem [SECTOR_BYTES];
    logic          strobe_d;
    logic          store_pending;
    logic [7:0]    byte_hold;
    sector_index_t write_index;
    logic          sector_full;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_d           <= 1'b0;
            store_pending      <= 1'b0;
            write_index        <= '0;
            sector_full        <= 1'b0;
            sd_cache_available <= 1'b0;
        end else begin
            // rising edge of the byte strobe, stored next cycle
            strobe_d      <= sd_byte_available;
            store_pending <= sd_byte_available && !strobe_d;
            sector_full   <= 1'b0;
            if (sd_rd_start) begin
                // new sector, old contents no longer valid
                write_index        <= '0;
                sd_cache_available <= 1'b0;
            end else begin
                if (store_pending) begin
                    // index wraps to 0 after the last byte
                    write_index <= write_index + 1'b1;
                    sector_full <= (write_index == SECTOR_LAST);
                end
                if (sector_full) begin
                    sd_cache_available <= 1'b1;
                end
            end
        end
    end

    // byte held one cycle to line up with store_pending
    always_ff @(posedge CLOCK_50) begin
        byte_hold <= sd_dout;
        if (store_pending) begin
            sector_mem[write_index] <= byte_hold;
        end
        // read port, address held by the master
        byte_out <= sector_mem[index];
    end

endmodule

//--- source/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import bus_pkg::*, periph_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    input  logic        key_pressed,
    input  key_code_t   ascii,
    input  logic        irq_ack,
    output irq_vector_t irq_vector,
    input  logic [7:0]  sd_dout,
    input  logic        sd_byte_available,
    input  logic        sd_ready,
    output logic [31:0] sd_sector_addr,
    output logic        sd_rd_start,
    output logic        uart_write,
    output logic [7:0]  uart_byte
);

    // fabric to ram
    ram_word_t     ram_read_word;
    logic          ram_read_strobe;
    logic          ram_write_strobe;
    logic [1:0]    ram_byte_offset;
    ram_index_t    ram_word_index;
    logic          ram_upper_half;
    // fabric to sector buffer
    logic [7:0]    sd_byte;
    sector_index_t sd_index;
    logic          sd_cache_available;
    // key unit to fabric
    key_code_t     key_code;

    bus_fabric u_fabric (
        .CLOCK_50           (CLOCK_50),
        .KEY0               (KEY0),
        .req                (bus_req),
        .rsp                (bus_rsp),
        .ram_read_word      (ram_read_word),
        .ram_read_strobe    (ram_read_strobe),
        .ram_write_strobe   (ram_write_strobe),
        .ram_byte_offset    (ram_byte_offset),
        .ram_word_index     (ram_word_index),
        .ram_upper_half     (ram_upper_half),
        .sd_byte            (sd_byte),
        .sd_index           (sd_index),
        .sd_cache_available (sd_cache_available),
        .sd_ready           (sd_ready),
        .key_code           (key_code),
        .sd_sector_addr     (sd_sector_addr),
        .sd_rd_start        (sd_rd_start),
        .uart_write         (uart_write),
        .uart_byte          (uart_byte)
    );

    // kind and store data come straight from the master
    word_ram u_ram (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .word_index   (ram_word_index),
        .byte_offset  (ram_byte_offset),
        .ls_type      (bus_req.ls_type),
        .write_data   (bus_req.write_data),
        .read_strobe  (ram_read_strobe),
        .write_strobe (ram_write_strobe),
        .upper_half   (ram_upper_half),
        .read_word    (ram_read_word)
    );

    sd_sector_buffer u_sd_buffer (
        .CLOCK_50           (CLOCK_50),
        .KEY0               (KEY0),
        .sd_dout            (sd_dout),
        .sd_byte_available  (sd_byte_available),
        .sd_rd_start        (sd_rd_start),
        .index              (sd_index),
        .byte_out           (sd_byte),
        .sd_cache_available (sd_cache_available)
    );

    key_irq_unit u_key_irq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .ascii       (ascii),
        .irq_ack     (irq_ack),
        .key_code    (key_code),
        .irq_vector  (irq_vector)
    );

endmodule

//--- source/word_ram.sv
`timescale 1ns/1ps

module word_ram import bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  ram_index_t word_index,
    input  logic [1:0] byte_offset,
    input  ls_type_t   ls_type,
    input  bus_data_t  write_data,
    input  logic       read_strobe,
    input  logic       write_strobe,
    input  logic       upper_half,
    output ram_word_t  read_word
);

    // little-endian words, byte 0 in bits 7:0
    ram_word_t  mem [RAM_WORDS];
    ram_index_t access_index;
    logic [3:0] lane_enable;
    ram_word_t  lane_data;

    // second step of a double goes to the next word
    assign access_index = upper_half ? ram_index_t'(word_index + 1'b1) : word_index;

    // byte lanes to touch and the data lined up to them
    always_comb begin
        if (upper_half) begin
            // high 32 bits of the double, full word
            lane_enable = 4'b1111;
            lane_data   = write_data[63:32];
        end else begin
            lane_data = ram_word_t'(write_data[31:0] << {byte_offset, 3'b000});
            case (ls_type)
                LS_BYTE: begin
                    lane_enable = 4'b0001 << byte_offset;
                end
                LS_HALF: begin
                    lane_enable = 4'b0011 << byte_offset;
                end
                LS_WORD, LS_DOUBLE: begin
                    lane_enable = 4'b1111;
                end
                default: begin
                    // unsigned kinds are loads only
                    lane_enable = 4'b1111;
                end
            endcase
        end
    end

    // store merge, one lane at a time
    always_ff @(posedge CLOCK_50) begin
        if (write_strobe) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_enable[lane]) begin
                    mem[access_index][8*lane +: 8] <= lane_data[8*lane +: 8];
                end
            end
        end
    end

    // registered read, addressed byte moved down to bit 0
    // upper bits fill with zero
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_word <= '0;
        end else if (read_strobe) begin
            read_word <= mem[access_index] >> {byte_offset, 3'b000};
        end
    end

endmodule

//--- verif/soc_bus_properties.sv
`timescale 1ns/1ps

module soc_bus_properties import bus_pkg::*; (
    input logic     CLOCK_50,
    input logic     KEY0,
    input bus_rsp_t rsp,
    input logic     uart_write,
    input logic     sd_rd_start
);

    // uart strobe lasts one cycle per store
    a_uart_single: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write
    ) else $error("uart_write high for two cycles in a row");

    // sector read start is a single pulse
    a_start_single: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start
    ) else $error("sd_rd_start high for two cycles in a row");

    // master issues one access at a time
    a_one_pending: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        rsp.read_done || rsp.write_done
    ) else $error("read_done and write_done both low");

endmodule

// checker on every fabric instance
bind bus_fabric soc_bus_properties u_properties (
    .CLOCK_50    (CLOCK_50),
    .KEY0        (KEY0),
    .rsp         (rsp),
    .uart_write  (uart_write),
    .sd_rd_start (sd_rd_start)
);

//--- verif/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus import bus_pkg::*, periph_pkg::*; ();

    localparam int BUS_TIMEOUT  = 50;
    localparam int AVAIL_POLLS  = 40;
    localparam int REGION_WORDS = 16;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic        key_pressed;
    key_code_t   ascii;
    logic        irq_ack;
    irq_vector_t irq_vector;
    logic [7:0]  sd_dout;
    logic        sd_byte_available;
    logic        sd_ready;
    logic [31:0] sd_sector_addr;
    logic        sd_rd_start;
    logic        uart_write;
    logic [7:0]  uart_byte;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          checks_before;
    int          errors_before;
    logic        hung;
    // cycles read_done stayed low on the last read
    int          read_cycles;
    // pulse counters written only by the sampler below
    int          uart_pulses = 0;
    int          start_pulses = 0;
    logic [7:0]  uart_seen = 8'h00;
    // reference copies of ram and sector contents
    ram_word_t   ram_model [RAM_WORDS];
    logic [7:0]  sector_model [SECTOR_BYTES];

    soc_bus_top UUT (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .bus_req           (bus_req),
        .bus_rsp           (bus_rsp),
        .key_pressed       (key_pressed),
        .ascii             (ascii),
        .irq_ack           (irq_ack),
        .irq_vector        (irq_vector),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .sd_sector_addr    (sd_sector_addr),
        .sd_rd_start       (sd_rd_start),
        .uart_write        (uart_write),
        .uart_byte         (uart_byte)
    );

    // 4 ns clock
    always #2 CLOCK_50 = ~CLOCK_50;

    // strobes sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (uart_write) begin
            uart_pulses = uart_pulses + 1;
            uart_seen   = uart_byte;
        end
        if (sd_rd_start) begin
            start_pulses = start_pulses + 1;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic report_mismatch(input string name, input bus_data_t got,
                                   input bus_data_t expected);
        error_count++;
        $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, expected);
    endtask

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t expected);
        check_count++;
        if (got !== expected)
            report_mismatch(name, got, expected);
    endtask

    task automatic check_byte(input string name, input key_code_t got, input key_code_t expected);
        check_count++;
        if (got !== expected)
            report_mismatch(name, bus_data_t'(got), bus_data_t'(expected));
    endtask

    task automatic check_vector(input string name, input irq_vector_t got,
                                input irq_vector_t expected);
        check_count++;
        if (got !== expected)
            report_mismatch(name, bus_data_t'(got), bus_data_t'(expected));
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected)
            report_mismatch(name, bus_data_t'(got), bus_data_t'(expected));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge CLOCK_50);
    endtask

    // one-cycle enable with fields held until done returns
    task automatic write_access(input bus_addr_t address, input ls_type_t kind,
                                input bus_data_t data);
        int waited;
        waited = 0;
        if (!hung) begin
            bus_req.address      = address;
            bus_req.ls_type      = kind;
            bus_req.write_data   = data;
            bus_req.write_enable = 1'b1;
            @(negedge CLOCK_50);
            bus_req.write_enable = 1'b0;
            while (!bus_rsp.write_done && waited < BUS_TIMEOUT) begin
                @(negedge CLOCK_50);
                waited++;
            end
            if (!bus_rsp.write_done) begin
                $display("timeout: write to %h did not finish in %0d cycles", address, waited);
                error_count++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic read_access(input bus_addr_t address, input ls_type_t kind,
                               output bus_data_t data);
        int waited;
        waited      = 0;
        data        = '0;
        read_cycles = 0;
        if (!hung) begin
            bus_req.address     = address;
            bus_req.ls_type     = kind;
            bus_req.read_enable = 1'b1;
            @(negedge CLOCK_50);
            bus_req.read_enable = 1'b0;
            while (!bus_rsp.read_done && waited < BUS_TIMEOUT) begin
                @(negedge CLOCK_50);
                waited++;
            end
            if (!bus_rsp.read_done) begin
                $display("timeout: read of %h did not finish in %0d cycles", address, waited);
                error_count++;
                hung = 1'b1;
            end
            read_cycles = waited;
            data        = bus_rsp.read_data;
        end
    endtask

    // little-endian merge into the reference words
    function automatic void model_store(input int index, input int offset,
                                        input ls_type_t kind, input bus_data_t data);
        case (kind)
            LS_BYTE:   ram_model[index][8*offset +: 8]  = data[7:0];
            LS_HALF:   ram_model[index][8*offset +: 16] = data[15:0];
            LS_DOUBLE: begin
                ram_model[index]     = data[31:0];
                ram_model[index + 1] = data[63:32];
            end
            default:   ram_model[index] = data[31:0];
        endcase
    endfunction

    // word moved down by the offset and zero filled
    // double spans two words
    function automatic bus_data_t model_load(input int index, input int offset,
                                             input ls_type_t kind);
        if (kind == LS_DOUBLE) begin
            return {ram_model[index + 1], ram_model[index]};
        end
        return bus_data_t'(ram_model[index] >> (8 * offset));
    endfunction

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - checks_before, error_count - errors_before);
        checks_before = check_count;
        errors_before = error_count;
    endtask

    task automatic reset_values();
        bus_data_t got;
        check_bit("read_done", bus_rsp.read_done, 1'b1);
        check_bit("write_done", bus_rsp.write_done, 1'b1);
        check_vector("irq_vector", irq_vector, IRQ_NONE);
        check_bit("uart_write", uart_write, 1'b0);
        check_bit("sd_rd_start", sd_rd_start, 1'b0);
        read_access(SDC_AVAIL, LS_WORD_U, got);
        check_data("sd available", got, 64'd0);
        end_test("reset");
    endtask

    task automatic ram_accesses();
        int        base;
        int        index;
        int        offset;
        ls_type_t  kind;
        bus_addr_t address;
        bus_data_t data;
        bus_data_t got;
        // even base keeps the region inside the ram
        base = 2 * (int'(random_bits(9)) % 504);
        // known contents first so no load sees an unwritten word
        for (int i = 0; i < REGION_WORDS; i++) begin
            data = random_bits(32);
            write_access(RAM_BASE + bus_addr_t'((base + i) * 4), LS_WORD, data);
            ram_model[base + i] = data[31:0];
        end
        for (int n = 0; n < 40; n++) begin
            kind   = ls_type_t'(random_bits(2));
            data   = random_bits(64);
            index  = base + int'(random_bits(4));
            offset = int'(random_bits(2));
            // natural alignment per width
            if (kind == LS_HALF)
                offset = offset & 2;
            if (kind == LS_WORD || kind == LS_DOUBLE)
                offset = 0;
            if (kind == LS_DOUBLE)
                index = index & ~1;
            address = RAM_BASE + bus_addr_t'(index * 4 + offset);
            write_access(address, kind, data);
            model_store(index, offset, kind, data);
            read_access(address, kind, got);
            check_data("ram read_data", got, model_load(index, offset, kind));
            // a double holds read_done low for two cycles
            check_data("ram read cycles", bus_data_t'(read_cycles),
                       (kind == LS_DOUBLE) ? 64'd2 : 64'd1);
        end
        // sweep the region at random byte offsets
        for (int i = 0; i < REGION_WORDS; i++) begin
            offset = int'(random_bits(2));
            read_access(RAM_BASE + bus_addr_t'((base + i) * 4 + offset), LS_WORD_U, got);
            check_data("ram read_data", got, model_load(base + i, offset, LS_WORD_U));
        end
        end_test("ram");
    endtask

    task automatic keyboard_irq();
        key_code_t code;
        bus_data_t got;
        code = key_code_t'(random_bits(7)) | 8'h20;
        ascii       = code;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        check_vector("irq_vector", irq_vector, IRQ_KEY);
        // held key gives no second press
        idle(2);
        key_pressed = 1'b0;
        ascii       = KEY_NONE;
        read_access(KEY_ADDR, LS_BYTE_U, got);
        check_byte("key code", got[7:0], code);
        check_data("key read_data", got, bus_data_t'(code));
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        check_vector("irq_vector", irq_vector, IRQ_NONE);
        // code zero is not a key
        key_pressed = 1'b1;
        idle(2);
        key_pressed = 1'b0;
        check_vector("irq_vector", irq_vector, IRQ_NONE);
        read_access(KEY_ADDR, LS_BYTE_U, got);
        check_byte("key code", got[7:0], code);
        end_test("keyboard");
    endtask

    task automatic uart_store();
        bus_data_t data;
        int        pulses_before;
        data          = random_bits(64);
        pulses_before = uart_pulses;
        write_access(UART_ADDR, LS_BYTE, data);
        idle(4);
        check_data("uart_write pulses", bus_data_t'(uart_pulses - pulses_before), 64'd1);
        check_byte("uart_byte", uart_seen, data[7:0]);
        check_bit("uart_write", uart_write, 1'b0);
        end_test("uart");
    endtask

    // two cycles per byte with the strobe high in the first
    task automatic stream_sector();
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            sector_model[i]   = 8'(random_bits(8));
            sd_dout           = sector_model[i];
            sd_byte_available = 1'b1;
            @(negedge CLOCK_50);
            sd_byte_available = 1'b0;
            @(negedge CLOCK_50);
        end
    endtask

    task automatic sd_sector_read();
        logic [31:0] sector;
        bus_data_t   got;
        int          index;
        int          polls;
        int          starts_before;
        sector = 32'(random_bits(32));
        write_access(SDC_ADDR_REG, LS_WORD, bus_data_t'(sector));
        check_data("sd_sector_addr", bus_data_t'(sd_sector_addr), bus_data_t'(sector));
        starts_before = start_pulses;
        write_access(SDC_READ, LS_WORD, 64'd1);
        idle(3);
        check_data("sd_rd_start pulses", bus_data_t'(start_pulses - starts_before), 64'd1);
        stream_sector();
        polls = 0;
        got   = '0;
        while (got !== 64'd1 && polls < AVAIL_POLLS && !hung) begin
            read_access(SDC_AVAIL, LS_WORD_U, got);
            polls++;
        end
        if (got !== 64'd1) begin
            $display("timeout: sector available bit still clear after %0d reads", polls);
            error_count++;
        end
        // both ends of the window plus random bytes
        for (int n = 0; n < 18; n++) begin
            index = (n == 0) ? 0 : (n == 1) ? SECTOR_BYTES - 1 : int'(random_bits(9));
            read_access(SDC_BASE + bus_addr_t'(index), LS_BYTE_U, got);
            check_data("sector byte", got, bus_data_t'(sector_model[index]));
        end
        sd_ready = 1'b1;
        read_access(SDC_READY, LS_WORD_U, got);
        check_data("sd ready", got, 64'd1);
        sd_ready = 1'b0;
        read_access(SDC_READY, LS_WORD_U, got);
        check_data("sd ready", got, 64'd0);
        // next sector read drops the flag at once
        write_access(SDC_READ, LS_WORD, 64'd1);
        read_access(SDC_AVAIL, LS_WORD_U, got);
        check_data("sd available", got, 64'd0);
        end_test("sd sector");
    endtask

    task automatic unmapped_read();
        bus_data_t got;
        // key register leaves nonzero data on the bus
        read_access(KEY_ADDR, LS_BYTE_U, got);
        read_access(64'h0000_5000, LS_DOUBLE, got);
        check_data("unmapped read_data", got, 64'd0);
        check_data("unmapped read cycles", bus_data_t'(read_cycles), 64'd1);
        read_access(RAM_LIMIT, LS_WORD_U, got);
        check_data("unmapped read_data", got, 64'd0);
        check_data("unmapped read cycles", bus_data_t'(read_cycles), 64'd1);
        end_test("unmapped");
    endtask

    initial begin
        lfsr_state        = 32'hecbd;
        check_count       = 0;
        error_count       = 0;
        checks_before     = 0;
        errors_before     = 0;
        hung              = 1'b0;
        read_cycles       = 0;
        KEY0              = 1'b0;
        bus_req           = '0;
        key_pressed       = 1'b0;
        ascii             = KEY_NONE;
        irq_ack           = 1'b0;
        sd_dout           = 8'h00;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        repeat (16) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        reset_values();
        ram_accesses();
        keyboard_irq();
        uart_store();
        sd_sector_read();
        unmapped_read();
        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
